/* filelist.f */
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/dataMem.sv
rtl/controlUnit.sv
rtl/datapath.sv
rtl/cpuTop.sv
testbench/clockGen.sv
testbench/cpu_checker.sv
testbench/cpuTb.sv

/* testbench/cpuTb.sv */
`timescale 1ns/1ps
module cpuTb;
	import isaPkg::*;
	import ctrlPkg::*;

	logic clk, rst, run, imemWrEn;
	imemAddr_t imemAddr;
	instr_t imemData;
	word_t pc, memAddr, memWrData;
	logic memWrEn, flagNeg, flagZero, flagOverf, flagCOut;
	instr_t prog[$];
	word_t expAddr[$];
	word_t expData[$];
	word_t opA, opB, lo, hi, val;
	int cycleCount = 0;

	clockGen uClk (.clk);

	cpuTop i_dut (
		.clk, .rst, .run, .imemWrEn, .imemAddr, .imemData, .pc,
		.memWrEn, .memAddr, .memWrData, .flagNeg, .flagZero, .flagOverf, .flagCOut
	);

	// instruction encoders
	function automatic instr_t rFormat(logic [10:0] op, regIdx_t rm, regIdx_t rn, regIdx_t rd);
		return {op, rm, 6'b000000, rn, rd};
	endfunction

	function automatic instr_t iFormat(logic [11:0] imm, regIdx_t rn, regIdx_t rd);
		return {OP_ADDI, imm, rn, rd};
	endfunction

	function automatic instr_t dFormat(logic [10:0] op, logic [8:0] offs,
		regIdx_t rn, regIdx_t rt);
		return {op, offs, 2'b00, rn, rt};
	endfunction

	function automatic instr_t bFormat(logic [5:0] op, logic [25:0] offs);
		return {op, offs};
	endfunction

	function automatic instr_t cbFormat(logic [18:0] offs, regIdx_t rt);
		return {OP_CBZ, offs, rt};
	endfunction

	function automatic string errorLine(string msg);
		return $sformatf("** Error @ %0t: %s", $time, msg);
	endfunction

	task automatic abortRun(string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic expectStore(word_t addr, word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	endtask

	// one instruction per cycle with the core idle
	task automatic loadProgram();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			imemWrEn <= 1'b1;
			imemAddr <= imemAddr_t'(i);
			imemData <= prog[i];
		end
		@(posedge clk);
		imemWrEn <= 1'b0;
	endtask

	// runs until the final self-branch is reached
	task automatic runProgram();
		word_t lastPc;
		lastPc = word_t'(4 * (prog.size() - 1));
		@(negedge clk);
		assert (pc == '0) else abortRun(errorLine($sformatf("pc %0h before run", pc)));
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (pc != lastPc) @(negedge clk);
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		assert (expAddr.size() == 0)
			else abortRun(errorLine($sformatf("%0d expected stores missing", expAddr.size())));
	endtask

	// store stream compared in order
	always @(negedge clk) begin
		if (memWrEn) begin
			assert (expAddr.size() != 0)
				else abortRun(errorLine($sformatf("unexpected store to %0h", memAddr)));
			assert (memAddr == expAddr[0] && memWrData == expData[0])
				else abortRun(errorLine($sformatf("store %0h <= %0h, expected %0h <= %0h",
					memAddr, memWrData, expAddr[0], expData[0])));
			void'(expAddr.pop_front());
			void'(expData.pop_front());
		end
	end

	// three programs of at most 40 instructions plus loading fit in 300 cycles
	always @(negedge clk) begin
		cycleCount++;
		if (cycleCount >= 300) begin
			abortRun("timeout: the programs did not finish within 300 cycles");
		end else if (i_dut.uChecker.failCount != 0) begin
			abortRun("an assertion on the core pc or store bus failed");
		end
	end

	initial begin
		void'($urandom(72571));
		rst = 1'b1;
		run = 1'b0;
		imemWrEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// alu ops, memory round trip, equal-operand SUBS
		opA = $urandom % 4096;
		opB = $urandom % 4096;
		prog = '{iFormat(opA[11:0], ZERO_REG, 5'd1), iFormat(opB[11:0], ZERO_REG, 5'd2),
			rFormat(OP_ADD, 5'd2, 5'd1, 5'd3), dFormat(OP_STUR, 9'd0, ZERO_REG, 5'd3),
			rFormat(OP_SUB, 5'd2, 5'd1, 5'd4), dFormat(OP_STUR, 9'd8, ZERO_REG, 5'd4),
			rFormat(OP_AND, 5'd2, 5'd1, 5'd5), dFormat(OP_STUR, 9'd16, ZERO_REG, 5'd5),
			rFormat(OP_ORR, 5'd2, 5'd1, 5'd6), dFormat(OP_STUR, 9'd24, ZERO_REG, 5'd6),
			dFormat(OP_LDUR, 9'd8, ZERO_REG, 5'd8), dFormat(OP_STUR, 9'd32, ZERO_REG, 5'd8),
			rFormat(OP_SUBS, 5'd1, 5'd1, 5'd9), rFormat(OP_ADD, 5'd2, 5'd1, 5'd10),
			bFormat(OP_B, 26'd0)};
		expectStore(0, opA + opB);
		expectStore(8, opA - opB);
		expectStore(16, opA & opB);
		expectStore(24, opA | opB);
		expectStore(32, opA - opB);
		loadProgram();
		runProgram();
		// equal operands leave no borrow and cannot overflow
		assert (flagZero && !flagNeg && flagCOut && !flagOverf)
			else abortRun(errorLine("flags wrong after SUBS of equal operands"));
		applyReset();

		// CBZ taken, CBZ not taken, B, then larger minus smaller
		val = 1 + $urandom % 4095;
		lo = $urandom % 2048;
		hi = lo + 1 + $urandom % 2047;
		prog = '{iFormat(val[11:0], ZERO_REG, 5'd1), cbFormat(19'd2, ZERO_REG),
			dFormat(OP_STUR, 9'd0, ZERO_REG, 5'd1), dFormat(OP_STUR, 9'd40, ZERO_REG, 5'd1),
			cbFormat(19'd2, 5'd1), dFormat(OP_STUR, 9'd48, ZERO_REG, 5'd1),
			bFormat(OP_B, 26'd2), dFormat(OP_STUR, 9'd56, ZERO_REG, 5'd1),
			iFormat(lo[11:0], ZERO_REG, 5'd2), iFormat(hi[11:0], ZERO_REG, 5'd3),
			rFormat(OP_SUBS, 5'd2, 5'd3, 5'd4), rFormat(OP_ADD, 5'd2, 5'd3, 5'd5),
			dFormat(OP_STUR, 9'd64, ZERO_REG, 5'd4), bFormat(OP_B, 26'd0)};
		expectStore(40, val);
		expectStore(48, val);
		expectStore(64, hi - lo);
		loadProgram();
		runProgram();
		// both operands small and positive, so no signed overflow
		assert (!flagNeg && flagCOut && !flagZero && !flagOverf)
			else abortRun(errorLine("flags wrong after SUBS of larger minus smaller"));
		applyReset();

		// BL link value and the zero register
		prog = '{iFormat(val[11:0], ZERO_REG, 5'd1), bFormat(OP_BL, 26'd2),
			dFormat(OP_STUR, 9'd0, ZERO_REG, 5'd1), dFormat(OP_STUR, 9'd72, ZERO_REG, LINK_REG),
			iFormat(val[11:0], 5'd1, ZERO_REG), dFormat(OP_STUR, 9'd80, ZERO_REG, ZERO_REG),
			bFormat(OP_B, 26'd0)};
		expectStore(72, 8);
		expectStore(80, 0);
		loadProgram();
		runProgram();

		if (i_dut.uChecker.failCount == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abortRun("an assertion on the core pc or store bus failed");
		end
	end

endmodule

/* testbench/cpu_checker.sv */
`timescale 1ns/1ps
module cpu_checker (
	input logic clk,
	input logic rst,
	input logic run,
	input isaPkg::word_t pc,
	input logic memWrEn,
	input logic isBranch,
	input logic isCondBranch
);
	int failCount = 0;

	// fetch is always word aligned
	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else begin
			$error("pc not 4-byte aligned: %h", pc);
			failCount++;
		end

	resetClearsPc: assert property (@(posedge clk) rst |=> pc == '0)
		else begin
			$error("pc not cleared by reset: %h", pc);
			failCount++;
		end

	idleHoldsPc: assert property (@(posedge clk) (!run && !rst) |=> $stable(pc))
		else begin
			$error("pc moved while the core was idle: %h", pc);
			failCount++;
		end

	// store bus stays quiet while idle or in reset
	idleNoStore: assert property (@(posedge clk) (!run || rst) |-> !memWrEn)
		else begin
			$error("data memory write while idle");
			failCount++;
		end

	sequentialStep: assert property (@(posedge clk) disable iff (rst)
		(run && !isBranch && !isCondBranch) |=> pc == $past(pc) + 4)
		else begin
			$error("pc did not advance by 4: %h", pc);
			failCount++;
		end

endmodule

bind cpuTop cpu_checker uChecker (
	.clk, .rst, .run, .pc, .memWrEn, .isBranch, .isCondBranch
);

/* testbench/clockGen.sv */
`timescale 1ns/1ps
module clockGen (
	output logic clk
);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

endmodule

/* rtl/cpuTop.sv */
`timescale 1ns/1ps
module cpuTop (
	input logic clk,
	input logic rst,
	input logic run,
	input logic imemWrEn,
	input ctrlPkg::imemAddr_t imemAddr,
	input isaPkg::instr_t imemData,
	output isaPkg::word_t pc,
	output logic memWrEn,
	output isaPkg::word_t memAddr,
	output isaPkg::word_t memWrData,
	output logic flagNeg,
	output logic flagZero,
	output logic flagOverf,
	output logic flagCOut
);
	import isaPkg::*;
	import ctrlPkg::*;

	instr_t imem [IMEM_WORDS];
	instr_t instr;
	word_t pcPlusFour;
	word_t nextPc;
	word_t brOffset;
	word_t cbOffset;
	logic coreActive;
	logic reg2Loc, aluSrc, memToReg, regWrite, memWrite, linkSel;
	logic setFlags, immSel, isBranch, isCondBranch, regZero;
	aluOp_t aluOp;

	// instruction load port, usable any cycle
	always_ff @(posedge clk) begin
		if (imemWrEn) begin
			imem[imemAddr] <= imemData;
		end
	end

	assign instr = imem[pc[INSTR_OFFSET_W +: IMEM_ADDR_W]];

	// nothing architectural changes while idle
	assign coreActive = run & ~rst;
	assign memWrEn = memWrite & coreActive;

	controlUnit uCtrl (
		.opcode(instr[OPCODE_LSB +: OPCODE_W]),
		.reg2Loc, .aluSrc, .memToReg, .regWrite, .memWrite, .linkSel,
		.setFlags, .isBranch, .isCondBranch, .immSel, .aluOp
	);

	datapath uDp (
		.clk, .rst,
		.rd(instr[RD_LSB +: REG_IDX_W]),
		.rn(instr[RN_LSB +: REG_IDX_W]),
		.rm(instr[RM_LSB +: REG_IDX_W]),
		.pcPlusFour(pcPlusFour),
		.dAddr9(instr[DADDR9_LSB +: DADDR9_W]),
		.aluImm12(instr[IMM12_LSB +: IMM12_W]),
		.reg2Loc, .aluSrc, .memToReg,
		.regWrite(regWrite & coreActive),
		.memWrite(memWrEn),
		.linkSel,
		.setFlags(setFlags & coreActive),
		.immSel, .aluOp, .regZero,
		.flagNeg, .flagZero, .flagOverf, .flagCOut,
		.memAddr, .memWrData
	);

	// word offsets, sign-extended and scaled to bytes
	assign brOffset = {{(WORD_W-IMM26_W-INSTR_OFFSET_W){instr[IMM26_LSB+IMM26_W-1]}},
		instr[IMM26_LSB +: IMM26_W], {INSTR_OFFSET_W{1'b0}}};
	assign cbOffset = {{(WORD_W-IMM19_W-INSTR_OFFSET_W){instr[IMM19_LSB+IMM19_W-1]}},
		instr[IMM19_LSB +: IMM19_W], {INSTR_OFFSET_W{1'b0}}};

	assign pcPlusFour = pc + 4;

	always_comb begin
		if (isBranch) begin
			nextPc = pc + brOffset;
		end else if (isCondBranch && regZero) begin
			nextPc = pc + cbOffset;
		end else begin
			nextPc = pcPlusFour;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (run) begin
			pc <= nextPc;
		end
	end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps
module datapath (
	input logic clk,
	input logic rst,
	input isaPkg::regIdx_t rd,
	input isaPkg::regIdx_t rn,
	input isaPkg::regIdx_t rm,
	input isaPkg::word_t pcPlusFour,
	input logic [isaPkg::DADDR9_W-1:0] dAddr9,
	input logic [isaPkg::IMM12_W-1:0] aluImm12,
	input logic reg2Loc,
	input logic aluSrc,
	input logic memToReg,
	input logic regWrite,
	input logic memWrite,
	input logic linkSel,
	input logic setFlags,
	input logic immSel,
	input ctrlPkg::aluOp_t aluOp,
	output logic regZero,
	output logic flagNeg,
	output logic flagZero,
	output logic flagOverf,
	output logic flagCOut,
	output isaPkg::word_t memAddr,
	output isaPkg::word_t memWrData
);
	import isaPkg::*;

	regIdx_t readReg2;
	regIdx_t writeReg;
	word_t readData1;
	word_t readData2;
	word_t writeData;
	word_t immExt;
	word_t aluB;
	word_t aluResult;
	word_t memReadData;
	logic aluNeg;
	logic aluZero;
	logic aluOverf;
	logic aluCOut;

	// stores and CBZ read Rt from the Rd field
	assign readReg2 = reg2Loc ? rd : rm;

	// ADDI immediate is unsigned, load/store offset is signed
	assign immExt = immSel ? {{(WORD_W-IMM12_W){1'b0}}, aluImm12}
		: {{(WORD_W-DADDR9_W){dAddr9[DADDR9_W-1]}}, dAddr9};

	assign aluB = aluSrc ? immExt : readData2;

	// BL sends the return address to X30
	assign writeReg = linkSel ? LINK_REG : rd;
	assign writeData = linkSel ? pcPlusFour : (memToReg ? memReadData : aluResult);

	regFile uRegFile (
		.clk, .rst,
		.readReg1(rn), .readReg2(readReg2), .writeReg(writeReg),
		.writeData(writeData), .regWrite(regWrite),
		.readData1(readData1), .readData2(readData2)
	);

	alu uAlu (
		.a(readData1), .b(aluB), .op(aluOp), .result(aluResult),
		.negative(aluNeg), .zero(aluZero), .overflow(aluOverf), .carryOut(aluCOut)
	);

	dataMem uDataMem (
		.clk, .address(aluResult), .writeEnable(memWrite),
		.writeData(readData2), .readData(memReadData)
	);

	// CBZ tests the second read port directly
	assign regZero = (readData2 == '0);
	assign memAddr = aluResult;
	assign memWrData = readData2;

	// flags only move on SUBS
	always_ff @(posedge clk) begin
		if (rst) begin
			flagNeg <= 1'b0;
			flagZero <= 1'b0;
			flagOverf <= 1'b0;
			flagCOut <= 1'b0;
		end else if (setFlags) begin
			flagNeg <= aluNeg;
			flagZero <= aluZero;
			flagOverf <= aluOverf;
			flagCOut <= aluCOut;
		end
	end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps
module controlUnit (
	input logic [isaPkg::OPCODE_W-1:0] opcode,
	output logic reg2Loc,
	output logic aluSrc,
	output logic memToReg,
	output logic regWrite,
	output logic memWrite,
	output logic linkSel,
	output logic setFlags,
	output logic isBranch,
	output logic isCondBranch,
	output logic immSel,
	output ctrlPkg::aluOp_t aluOp
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		// defaults leave unknown opcodes harmless
		reg2Loc = 1'b0;
		aluSrc = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		linkSel = 1'b0;
		setFlags = 1'b0;
		isBranch = 1'b0;
		isCondBranch = 1'b0;
		immSel = 1'b0;
		aluOp = ALU_PASSB;

		if (opcode == OP_ADD) begin
			regWrite = 1'b1;
			aluOp = ALU_ADD;
		end else if (opcode == OP_SUB) begin
			regWrite = 1'b1;
			aluOp = ALU_SUB;
		end else if (opcode == OP_AND) begin
			regWrite = 1'b1;
			aluOp = ALU_AND;
		end else if (opcode == OP_ORR) begin
			regWrite = 1'b1;
			aluOp = ALU_ORR;
		end else if (opcode == OP_SUBS) begin
			regWrite = 1'b1;
			setFlags = 1'b1;
			aluOp = ALU_SUB;
		end else if (opcode == OP_LDUR) begin
			aluSrc = 1'b1;
			memToReg = 1'b1;
			regWrite = 1'b1;
			aluOp = ALU_ADD;
		end else if (opcode == OP_STUR) begin
			// Rt comes in through the Rd field
			reg2Loc = 1'b1;
			aluSrc = 1'b1;
			memWrite = 1'b1;
			aluOp = ALU_ADD;
		end else if (opcode[OPCODE_W-1 -: $bits(OP_ADDI)] == OP_ADDI) begin
			aluSrc = 1'b1;
			immSel = 1'b1;
			regWrite = 1'b1;
			aluOp = ALU_ADD;
		end else if (opcode[OPCODE_W-1 -: $bits(OP_CBZ)] == OP_CBZ) begin
			reg2Loc = 1'b1;
			isCondBranch = 1'b1;
		end else if (opcode[OPCODE_W-1 -: $bits(OP_B)] == OP_B) begin
			isBranch = 1'b1;
		end else if (opcode[OPCODE_W-1 -: $bits(OP_BL)] == OP_BL) begin
			isBranch = 1'b1;
			regWrite = 1'b1;
			linkSel = 1'b1;
		end
	end

endmodule

/* rtl/dataMem.sv */
`timescale 1ns/1ps
module dataMem (
	input logic clk,
	input isaPkg::word_t address,
	input logic writeEnable,
	input isaPkg::word_t writeData,
	output isaPkg::word_t readData
);
	import isaPkg::*;
	import ctrlPkg::*;

	word_t mem [DMEM_WORDS];
	logic [DMEM_ADDR_W-1:0] wordIdx;

	// word index sits above the byte offset, upper bits wrap
	assign wordIdx = address[WORD_OFFSET_W +: DMEM_ADDR_W];

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			mem[wordIdx] <= writeData;
		end
	end

	assign readData = mem[wordIdx];

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps
module regFile (
	input logic clk,
	input logic rst,
	input isaPkg::regIdx_t readReg1,
	input isaPkg::regIdx_t readReg2,
	input isaPkg::regIdx_t writeReg,
	input isaPkg::word_t writeData,
	input logic regWrite,
	output isaPkg::word_t readData1,
	output isaPkg::word_t readData2
);
	import isaPkg::*;

	word_t regs [2**REG_IDX_W];

	// X31 is never written, it only gets cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**REG_IDX_W; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && (writeReg != ZERO_REG)) begin
			regs[writeReg] <= writeData;
		end
	end

	// combinational reads, zero register forced
	assign readData1 = (readReg1 == ZERO_REG) ? '0 : regs[readReg1];
	assign readData2 = (readReg2 == ZERO_REG) ? '0 : regs[readReg2];

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps
module alu (
	input isaPkg::word_t a,
	input isaPkg::word_t b,
	input ctrlPkg::aluOp_t op,
	output isaPkg::word_t result,
	output logic negative,
	output logic zero,
	output logic overflow,
	output logic carryOut
);
	import isaPkg::*;
	import ctrlPkg::*;

	// one extra bit holds the carry
	logic [WORD_W:0] sumExt;
	logic [WORD_W:0] diffExt;

	assign sumExt = {1'b0, a} + {1'b0, b};
	// a - b as a + ~b + 1, carry set means no borrow
	assign diffExt = {1'b0, a} + {1'b0, ~b} + 1'b1;

	always_comb begin
		result = '0;
		overflow = 1'b0;
		carryOut = 1'b0;
		case (op)
			ALU_PASSB: result = b;
			ALU_ADD: begin
				result = sumExt[WORD_W-1:0];
				carryOut = sumExt[WORD_W];
				// same-sign operands, result sign flipped
				overflow = (a[WORD_W-1] == b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
			end
			ALU_SUB: begin
				result = diffExt[WORD_W-1:0];
				carryOut = diffExt[WORD_W];
				overflow = (a[WORD_W-1] != b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
			end
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			default: result = '0;
		endcase
	end

	assign negative = result[WORD_W-1];
	assign zero = (result == '0);

endmodule

/* rtl/ctrlPkg.sv */
package ctrlPkg;

	// alu operation select
	localparam int ALU_OP_W = 3;
	typedef logic [ALU_OP_W-1:0] aluOp_t;

	localparam aluOp_t ALU_PASSB = 3'b000;
	localparam aluOp_t ALU_ADD = 3'b010;
	localparam aluOp_t ALU_SUB = 3'b011;
	localparam aluOp_t ALU_AND = 3'b100;
	localparam aluOp_t ALU_ORR = 3'b101;

	// instruction memory
	localparam int IMEM_WORDS = 64;
	localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
	typedef logic [IMEM_ADDR_W-1:0] imemAddr_t;

	// data memory, 8-byte words
	localparam int DMEM_WORDS = 32;
	localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

	// byte offset bits below the word index
	localparam int WORD_OFFSET_W = 3;
	localparam int INSTR_OFFSET_W = 2;

endpackage

/* rtl/isaPkg.sv */
package isaPkg;

	// basic widths
	localparam int WORD_W = 64;
	localparam int INSTR_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPCODE_W = 11;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] regIdx_t;
	typedef logic [INSTR_W-1:0] instr_t;

	// R and D format opcodes, full 11 bits
	localparam logic [10:0] OP_ADD = 11'b10001011000;
	localparam logic [10:0] OP_SUB = 11'b11001011000;
	localparam logic [10:0] OP_AND = 11'b10001010000;
	localparam logic [10:0] OP_ORR = 11'b10101010000;
	localparam logic [10:0] OP_SUBS = 11'b11101011000;
	localparam logic [10:0] OP_LDUR = 11'b11111000010;
	localparam logic [10:0] OP_STUR = 11'b11111000000;

	// shorter opcodes, matched against the top bits of the field
	localparam logic [9:0] OP_ADDI = 10'b1001000100;
	localparam logic [7:0] OP_CBZ = 8'b10110100;
	localparam logic [5:0] OP_B = 6'b000101;
	localparam logic [5:0] OP_BL = 6'b100101;

	// special registers
	localparam regIdx_t LINK_REG = 5'd30;
	localparam regIdx_t ZERO_REG = 5'd31;

	// instruction field positions
	localparam int OPCODE_LSB = 21;
	localparam int RD_LSB = 0;
	localparam int RN_LSB = 5;
	localparam int RM_LSB = 16;
	localparam int DADDR9_LSB = 12;
	localparam int IMM12_LSB = 10;
	localparam int IMM19_LSB = 5;
	localparam int IMM26_LSB = 0;

	// immediate field widths
	localparam int DADDR9_W = 9;
	localparam int IMM12_W = 12;
	localparam int IMM19_W = 19;
	localparam int IMM26_W = 26;

endpackage
